// ==== soc_config.svh ====
// Address map, memory sizes and bus widths; include wherever these macros are needed
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------
`define SOC_ADDR_W          32
`define SOC_DATA_W          64
`define SOC_BE_W            8
// Byte offset bits within a word
`define SOC_OFS_W           3
// Word index bits, enough for the DRAM
`define SOC_IDX_W           8

// ----------------------------------------
// Address map
// ----------------------------------------
`define SOC_ROM_BASE        32'h0001_0000
`define SOC_ROM_WORDS       8
`define SOC_DRAM_BASE       32'h8000_0000
`define SOC_DRAM_WORDS      256
// Last DRAM word doubles as program exit word
`define SOC_EXIT_ADDR       (`SOC_DRAM_BASE + 32'h7F8)

// ----------------------------------------
// Control
// ----------------------------------------
// Cycles after power-on reset with debug requests held off
`define SOC_DEBUG_DELAY     20
`define SOC_RST_SYNC_STAGES 2

`endif

// ==== soc_pkg.sv ====
// Shared bus record types, target encoding and boot image; import into bus stages and testbench
`default_nettype none

`include "soc_config.svh"

package soc_pkg;

  // Request from the outside, sampled by decode
  typedef struct packed {
    logic                   valid;
    logic                   we;
    logic [`SOC_ADDR_W-1:0] addr;
    logic [`SOC_BE_W-1:0]   be;
    logic [`SOC_DATA_W-1:0] wdata;
  } bus_req_t;

  typedef enum logic [1:0] {
    TGT_ROM  = 2'd0,
    TGT_DRAM = 2'd1,
    TGT_ERR  = 2'd2
  } target_e;

  // Decode to execute
  typedef struct packed {
    logic                   valid;
    logic                   we;
    target_e                target;
    logic [`SOC_IDX_W-1:0]  idx;
    logic [`SOC_BE_W-1:0]   be;
    logic [`SOC_DATA_W-1:0] wdata;
    logic                   is_exit;
  } dec_req_t;

  // Execute to result
  typedef struct packed {
    logic                   valid;
    logic                   we;
    target_e                target;
    logic [`SOC_BE_W-1:0]   be;
    logic [`SOC_DATA_W-1:0] rdata;
  } exe_res_t;

  typedef struct packed {
    logic                   valid;
    logic                   err;
    logic [`SOC_DATA_W-1:0] rdata;
  } bus_rsp_t;

  // Boot code, word 0 at the ROM base
  localparam logic [`SOC_DATA_W-1:0] boot_image [`SOC_ROM_WORDS] = '{
    64'h0000_0297_f140_2573,
    64'h0202_8593_0182_b283,
    64'h0002_8067_0000_0013,
    64'h8000_0537_0010_0593,
    64'h00b5_3023_0000_0013,
    64'h1050_0073_ffdf_f06f,
    64'hdead_beef_cafe_f00d,
    64'h0123_4567_89ab_cdef
  };

endpackage

`default_nettype wire

// ==== soc_ctrl.sv ====
// Bus reset synchronizer and debug request gate; instantiated once in the top level
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module soc_ctrl (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic ndmreset_i,
  input  wire logic debug_req_i,
  input  wire logic debug_enable_i,
  output logic      bus_rst_no,
  output logic      debug_req_o
);

  localparam int unsigned SyncW = `SOC_RST_SYNC_STAGES;
  localparam int unsigned CntW  = $clog2(`SOC_DEBUG_DELAY + 1);

  logic             rst_comb_n;
  logic [SyncW-1:0] sync_q;
  logic [CntW-1:0]  del_cnt_q;

  // ----------------------------------------
  // Bus reset
  // ----------------------------------------
  // Power-on or debug module reset, asserted asynchronously
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  // Release walks a one through the chain
  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[SyncW-2:0], 1'b1};
    end
  end

  assign bus_rst_no = sync_q[SyncW-1];

  // ----------------------------------------
  // Debug gate
  // ----------------------------------------
  // Boot code runs first, so requests wait for the counter
  // Only power-on reset reloads it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      del_cnt_q <= CntW'(`SOC_DEBUG_DELAY);
    end else if (del_cnt_q != '0) begin
      del_cnt_q <= del_cnt_q - CntW'(1);
    end
  end

  assign debug_req_o = (del_cnt_q == '0) & debug_req_i & debug_enable_i;

endmodule

`default_nettype wire

// ==== bus_decode.sv ====
// First bus stage, maps each request address to a target and word index for execute
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module bus_decode
  import soc_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire bus_req_t req_i,
  output dec_req_t      dec_o
);

  // Exclusive window ends
  localparam logic [`SOC_ADDR_W-1:0] RomEnd  =
    `SOC_ROM_BASE + (`SOC_ROM_WORDS * `SOC_BE_W);
  localparam logic [`SOC_ADDR_W-1:0] DramEnd =
    `SOC_DRAM_BASE + (`SOC_DRAM_WORDS * `SOC_BE_W);

  logic     rom_hit;
  logic     dram_hit;
  dec_req_t dec_d;

  assign rom_hit  = (req_i.addr >= `SOC_ROM_BASE) && (req_i.addr < RomEnd);
  assign dram_hit = (req_i.addr >= `SOC_DRAM_BASE) && (req_i.addr < DramEnd);

  always_comb begin
    dec_d.valid   = req_i.valid;
    dec_d.we      = req_i.we;
    dec_d.idx     = req_i.addr[`SOC_OFS_W +: `SOC_IDX_W];
    dec_d.be      = req_i.be;
    dec_d.wdata   = req_i.wdata;
    dec_d.is_exit = (req_i.addr == `SOC_EXIT_ADDR);
    // ROM writes and holes in the map go to the error target
    if (dram_hit) begin
      dec_d.target = TGT_DRAM;
    end else if (rom_hit && !req_i.we) begin
      dec_d.target = TGT_ROM;
    end else begin
      dec_d.target = TGT_ERR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_o.valid <= 1'b0;
    end else begin
      dec_o <= dec_d;
    end
  end

endmodule

`default_nettype wire

// ==== mem_execute.sv ====
// Second bus stage, performs boot ROM and DRAM accesses and latches the exit word
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module mem_execute
  import soc_pkg::*;
(
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire dec_req_t         dec_i,
  output exe_res_t              res_o,
  output logic [`SOC_DATA_W-1:0] exit_o
);

  localparam int unsigned RomIdxW = $clog2(`SOC_ROM_WORDS);

  logic [`SOC_DATA_W-1:0] dram_q [`SOC_DRAM_WORDS];
  logic                   dram_wr;
  logic                   exit_wr;
  logic [`SOC_DATA_W-1:0] rd_data;

  assign dram_wr = dec_i.valid && dec_i.we && (dec_i.target == TGT_DRAM);
  // Partial writes to the exit word leave exit_o alone
  assign exit_wr = dram_wr && dec_i.is_exit && (&dec_i.be);

  // ----------------------------------------
  // DRAM array
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (dram_wr) begin
      for (int b = 0; b < `SOC_BE_W; b++) begin
        if (dec_i.be[b]) begin
          dram_q[dec_i.idx][8*b +: 8] <= dec_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // ----------------------------------------
  // Read source
  // ----------------------------------------
  // Error target does no access
  always_comb begin
    case (dec_i.target)
      TGT_ROM:  rd_data = boot_image[dec_i.idx[RomIdxW-1:0]];
      TGT_DRAM: rd_data = dram_q[dec_i.idx];
      default:  rd_data = '0;
    endcase
  end

  // ----------------------------------------
  // Stage register and exit word
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_o.valid <= 1'b0;
      exit_o      <= '0;
    end else begin
      res_o.valid  <= dec_i.valid;
      res_o.we     <= dec_i.we;
      res_o.target <= dec_i.target;
      res_o.be     <= dec_i.be;
      res_o.rdata  <= rd_data;
      if (exit_wr) begin
        exit_o <= dec_i.wdata;
      end
    end
  end

endmodule

`default_nettype wire

// ==== bus_result.sv ====
// Third bus stage, masks byte lanes, flags errors and registers the bus response
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module bus_result
  import soc_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire exe_res_t res_i,
  output bus_rsp_t      rsp_o
);

  logic                   rd_ok;
  logic [`SOC_DATA_W-1:0] lane_data;

  // Only good reads carry data back
  assign rd_ok = res_i.valid && !res_i.we && (res_i.target != TGT_ERR);

  // Disabled byte lanes read as zero
  always_comb begin
    lane_data = '0;
    for (int b = 0; b < `SOC_BE_W; b++) begin
      if (res_i.be[b]) begin
        lane_data[8*b +: 8] = res_i.rdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_o.valid <= 1'b0;
    end else begin
      rsp_o.valid <= res_i.valid;
      rsp_o.err   <= res_i.valid && (res_i.target == TGT_ERR);
      rsp_o.rdata <= rd_ok ? lane_data : '0;
    end
  end

endmodule

`default_nettype wire

// ==== soc_top.sv ====
// Top level of the single-core system bus, connects control and the three bus stages
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module soc_top
  import soc_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              ndmreset_i,
  input  wire bus_req_t          req_i,
  output bus_rsp_t               rsp_o,
  output logic [`SOC_DATA_W-1:0] exit_o,
  input  wire logic              debug_req_i,
  input  wire logic              debug_enable_i,
  output logic                   debug_req_o
);

  logic     bus_rst_n;
  dec_req_t dec;
  exe_res_t res;

  // ----------------------------------------
  // Reset and debug control
  // ----------------------------------------
  soc_ctrl i_soc_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .ndmreset_i     ( ndmreset_i     ),
    .debug_req_i    ( debug_req_i    ),
    .debug_enable_i ( debug_enable_i ),
    .bus_rst_no     ( bus_rst_n      ),
    .debug_req_o    ( debug_req_o    )
  );

  // ----------------------------------------
  // Bus pipeline
  // ----------------------------------------
  bus_decode i_bus_decode (
    .clk_i  ( clk_i     ),
    .rst_ni ( bus_rst_n ),
    .req_i  ( req_i     ),
    .dec_o  ( dec       )
  );

  mem_execute i_mem_execute (
    .clk_i  ( clk_i     ),
    .rst_ni ( bus_rst_n ),
    .dec_i  ( dec       ),
    .res_o  ( res       ),
    .exit_o ( exit_o    )
  );

  bus_result i_bus_result (
    .clk_i  ( clk_i     ),
    .rst_ni ( bus_rst_n ),
    .res_i  ( res       ),
    .rsp_o  ( rsp_o     )
  );

endmodule

`default_nettype wire

// ==== tb_soc_top.sv ====
// Self-checking testbench for the system bus top level, built and run by run.sh
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module tb_soc_top
  import soc_pkg::*;
();

  localparam logic [31:0] DramBytes = `SOC_DRAM_WORDS * `SOC_BE_W;
  localparam logic [31:0] RomBytes  = `SOC_ROM_WORDS * `SOC_BE_W;
  localparam int unsigned RomIdxW   = $clog2(`SOC_ROM_WORDS);

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  logic                   ndmreset_i;
  logic                   debug_req_i;
  logic                   debug_enable_i;
  logic                   debug_req_o;
  bus_req_t               req_i;
  bus_rsp_t               rsp_o;
  logic [`SOC_DATA_W-1:0] exit_o;

  // Reference model state
  logic [`SOC_DATA_W-1:0] dram_model [`SOC_DRAM_WORDS];
  logic [`SOC_DATA_W-1:0] exp_exit;
  bus_rsp_t               exp_q [$];
  bus_rsp_t               exp_head;
  logic [31:0]            lfsr_q = 32'hbf98_9cc6;
  string                  test_name;

  soc_top uut (.*);

  always #20 clk_i = ~clk_i;

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_rsp(input bus_rsp_t exp, input bus_rsp_t act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s: expected %h, actual %h", test_name, exp, act));
    end
  endtask

  task automatic check_exit(input logic [`SOC_DATA_W-1:0] exp, input logic [`SOC_DATA_W-1:0] act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s: expected %h, actual %h", test_name, exp, act));
    end
  endtask

  task automatic check_debug(input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s: expected %b, actual %b", test_name, exp, act));
    end
  endtask

  // ----------------------------------------
  // Random numbers and reference model
  // ----------------------------------------
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] word_addr(input logic [31:0] base, input logic [7:0] idx);
    return base + {21'd0, idx, 3'd0};
  endfunction

  function automatic bus_rsp_t expect_rsp(input bus_req_t r);
    bus_rsp_t               e;
    logic [31:0]            dram_ofs;
    logic [31:0]            rom_ofs;
    logic [`SOC_DATA_W-1:0] word;
    dram_ofs = r.addr - `SOC_DRAM_BASE;
    rom_ofs  = r.addr - `SOC_ROM_BASE;
    e        = '{valid: 1'b1, err: 1'b0, rdata: '0};
    word     = '0;
    if (dram_ofs < DramBytes) begin
      word = dram_model[dram_ofs[3 +: `SOC_IDX_W]];
    end else if (rom_ofs < RomBytes && !r.we) begin
      word = boot_image[rom_ofs[3 +: RomIdxW]];
    end else begin
      e.err = 1'b1;
    end
    // Reads return enabled lanes only, writes and errors carry no data
    for (int b = 0; b < `SOC_BE_W; b++) begin
      if (!e.err && !r.we && r.be[b]) begin
        e.rdata[8*b +: 8] = word[8*b +: 8];
      end
    end
    return e;
  endfunction

  task automatic update_model(input bus_req_t r);
    logic [31:0] dram_ofs;
    dram_ofs = r.addr - `SOC_DRAM_BASE;
    if (r.we && dram_ofs < DramBytes) begin
      for (int b = 0; b < `SOC_BE_W; b++) begin
        if (r.be[b]) begin
          dram_model[dram_ofs[3 +: `SOC_IDX_W]][8*b +: 8] = r.wdata[8*b +: 8];
        end
      end
      if (r.addr == `SOC_EXIT_ADDR && r.be == 8'hFF) begin
        exp_exit = r.wdata;
      end
    end
  endtask

  // ----------------------------------------
  // Bus driver
  // ----------------------------------------
  task automatic issue(input logic we, input logic [31:0] addr, input logic [7:0] be,
                       input logic [63:0] wdata);
    bus_req_t r;
    r = '{valid: 1'b1, we: we, addr: addr, be: be, wdata: wdata};
    @(posedge clk_i);
    req_i <= r;
    exp_q.push_back(expect_rsp(r));
    update_model(r);
  endtask

  // Idle the bus until every response is back
  task automatic drain();
    int unsigned n;
    @(posedge clk_i);
    req_i <= '0;
    n = 0;
    while (exp_q.size() != 0) begin
      if (n == 20) begin
        report_failure("timeout while waiting for outstanding bus responses");
      end
      @(posedge clk_i);
      n++;
    end
    @(negedge clk_i);
  endtask

  always @(negedge clk_i) begin
    if (rsp_o.valid) begin
      if (exp_q.size() == 0) begin
        report_failure("a response arrived with no request outstanding");
      end else begin
        exp_head = exp_q.pop_front();
        check_rsp(exp_head, rsp_o);
      end
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin : stimulus
    logic [7:0] idx;
    logic [7:0] be;
    rst_ni         <= 1'b0;
    ndmreset_i     <= 1'b0;
    debug_req_i    <= 1'b1;
    debug_enable_i <= 1'b1;
    req_i          <= '0;
    exp_exit       = '0;
    test_name      = "reset";
    repeat (7) @(posedge clk_i);
    @(negedge clk_i);
    check_debug(1'b0, debug_req_o);
    check_exit('0, exit_o);
    @(posedge clk_i);
    rst_ni <= 1'b1;

    // Gate stays shut for the start-up window, then follows the inputs
    test_name = "debug_gate";
    for (int i = 0; i < `SOC_DEBUG_DELAY; i++) begin
      @(negedge clk_i);
      check_debug(1'b0, debug_req_o);
      @(posedge clk_i);
    end
    for (int i = 0; i < 5; i++) begin
      @(negedge clk_i);
      check_debug(debug_req_i & debug_enable_i, debug_req_o);
      @(posedge clk_i);
      debug_req_i    <= (i != 1);
      debug_enable_i <= (i != 2);
    end

    test_name = "dram_fill";
    for (int w = 0; w < `SOC_DRAM_WORDS; w++) begin
      issue(1'b1, word_addr(`SOC_DRAM_BASE, 8'(w)), 8'hFF,
            {~word_addr(`SOC_DRAM_BASE, 8'(w)), word_addr(`SOC_DRAM_BASE, 8'(w))});
    end
    drain();
    check_exit(exp_exit, exit_o);

    test_name = "dram_random";
    for (int k = 0; k < 24; k++) begin
      idx = 8'(rand_bits(8));
      be  = (k % 3 == 0) ? 8'hFF : 8'(rand_bits(8));
      issue(1'b1, word_addr(`SOC_DRAM_BASE, idx), be, rand_bits(64));
      if (k % 4 == 1) begin
        issue(1'b0, word_addr(`SOC_DRAM_BASE, idx), 8'hFF, '0);
      end
    end
    for (int k = 0; k < 24; k++) begin
      idx = 8'(rand_bits(8));
      be  = 8'(rand_bits(8));
      issue(1'b0, word_addr(`SOC_DRAM_BASE, idx), be, '0);
    end
    drain();

    test_name = "rom";
    for (int w = 0; w < `SOC_ROM_WORDS; w++) begin
      issue(1'b0, word_addr(`SOC_ROM_BASE, 8'(w)), 8'hFF, '0);
    end
    issue(1'b1, word_addr(`SOC_ROM_BASE, 8'd3), 8'hFF, rand_bits(64));
    issue(1'b0, word_addr(`SOC_ROM_BASE, 8'd3), 8'hFF, '0);
    issue(1'b0, word_addr(`SOC_ROM_BASE, 8'd5), 8'h3C, '0);
    drain();

    test_name = "unmapped";
    issue(1'b0, 32'h0000_0000, 8'hFF, '0);
    // Former GPIO window
    issue(1'b0, 32'h4000_0000, 8'hFF, '0);
    issue(1'b1, 32'h4000_0008, 8'hFF, rand_bits(64));
    issue(1'b0, word_addr(`SOC_ROM_BASE, 8'(`SOC_ROM_WORDS)), 8'hFF, '0);
    issue(1'b0, `SOC_DRAM_BASE + DramBytes, 8'hFF, '0);
    issue(1'b1, `SOC_DRAM_BASE - 32'd8, 8'hFF, rand_bits(64));
    drain();

    test_name = "exit_word";
    issue(1'b1, `SOC_EXIT_ADDR, 8'hFF, rand_bits(64));
    drain();
    check_exit(exp_exit, exit_o);
    issue(1'b1, `SOC_EXIT_ADDR, 8'h0F, rand_bits(64));
    issue(1'b0, `SOC_EXIT_ADDR, 8'hFF, '0);
    drain();
    check_exit(exp_exit, exit_o);

    // Bus reset clears exit_o but neither the DRAM nor the debug gate
    test_name = "ndm_reset";
    @(posedge clk_i);
    ndmreset_i <= 1'b1;
    exp_exit = '0;
    repeat (3) begin
      @(negedge clk_i);
      check_exit(exp_exit, exit_o);
      check_debug(1'b1, debug_req_o);
      @(posedge clk_i);
    end
    ndmreset_i <= 1'b0;
    repeat (`SOC_RST_SYNC_STAGES) @(posedge clk_i);
    for (int k = 0; k < 16; k++) begin
      idx = 8'(rand_bits(8));
      issue(1'b0, word_addr(`SOC_DRAM_BASE, idx), 8'hFF, '0);
    end
    issue(1'b0, `SOC_EXIT_ADDR, 8'hFF, '0);
    drain();
    check_exit(exp_exit, exit_o);
    check_debug(1'b1, debug_req_o);

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
soc_pkg.sv
soc_ctrl.sv
bus_decode.sv
mem_execute.sv
bus_result.sv
soc_top.sv
tb_soc_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the bus testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_soc_top -o tb_soc_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_soc_top > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0
